// File: Bender.yml
package:
  name: ooo_issue_cluster

sources:
  - files:
      - design/ooo_issue_pkg.sv
      - design/busy_table.sv
      - design/rs_bank.sv
      - design/issue_arbiter.sv
      - design/issue_cluster.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_issue_cluster.sv

// File: design/busy_table.sv
`timescale 1ns/1ps

module busy_table import ooo_issue_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   // Dispatch marks a destination register as pending.
   input  logic      set_en,
   input  preg_t     set_prd,
   // Writeback releases a register.
   input  logic      clr_en,
   input  preg_t     clr_prd,
   output busy_vec_t busy
);

   busy_vec_t busy_q;
   busy_vec_t set_mask;
   busy_vec_t clr_mask;
   busy_vec_t busy_nxt;

   always_comb
   begin
      set_mask = '0;
      clr_mask = '0;
      if (set_en)
         set_mask = busy_vec_t'(1) << set_prd;   // One-hot set.
      if (clr_en)
         clr_mask = busy_vec_t'(1) << clr_prd;   // One-hot clear.
      // Set is applied last so it wins over a clear of the same tag.
      busy_nxt = (busy_q & ~clr_mask) | set_mask;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         busy_q <= '0;                            // All registers available.
      else
         busy_q <= busy_nxt;
   end

   assign busy = busy_q;   // Read straight from state, no extra stage.

endmodule

// File: design/issue_arbiter.sv
`timescale 1ns/1ps

module issue_arbiter import ooo_issue_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // ALU bank selection.
   input  logic    alu_valid,
   input  opcode_t alu_opc,
   input  imm_t    alu_imm,
   input  preg_t   alu_prs1,
   input  logic    alu_prs1_re,
   input  preg_t   alu_prs2,
   input  logic    alu_prs2_re,
   input  preg_t   alu_prd,
   input  logic    alu_prd_we,
   input  rob_id_t alu_rob_id,
   output logic    alu_pop,
   // LSU bank selection.
   input  logic    lsu_valid,
   input  opcode_t lsu_opc,
   input  imm_t    lsu_imm,
   input  preg_t   lsu_prs1,
   input  logic    lsu_prs1_re,
   input  preg_t   lsu_prs2,
   input  logic    lsu_prs2_re,
   input  preg_t   lsu_prd,
   input  logic    lsu_prd_we,
   input  rob_id_t lsu_rob_id,
   output logic    lsu_pop,
   // Issue port.
   input  logic    issue_accept,
   output logic    issue_valid,
   output unit_t   issue_unit,
   output opcode_t issue_opc,
   output imm_t    issue_imm,
   output preg_t   issue_prs1,
   output logic    issue_prs1_re,
   output preg_t   issue_prs2,
   output logic    issue_prs2_re,
   output preg_t   issue_prd,
   output logic    issue_prd_we,
   output rob_id_t issue_rob_id
);

   unit_t ptr_q;   // Preferred bank when both are valid.
   logic  pick_lsu;

   assign pick_lsu    = lsu_valid & (~alu_valid | (ptr_q == UNIT_LSU));
   assign issue_valid = alu_valid | lsu_valid;
   assign issue_unit  = pick_lsu ? UNIT_LSU : UNIT_ALU;

   assign alu_pop = issue_accept & alu_valid & ~pick_lsu;
   assign lsu_pop = issue_accept & pick_lsu;

   assign issue_opc     = pick_lsu ? lsu_opc     : alu_opc;
   assign issue_imm     = pick_lsu ? lsu_imm     : alu_imm;
   assign issue_prs1    = pick_lsu ? lsu_prs1    : alu_prs1;
   assign issue_prs1_re = pick_lsu ? lsu_prs1_re : alu_prs1_re;
   assign issue_prs2    = pick_lsu ? lsu_prs2    : alu_prs2;
   assign issue_prs2_re = pick_lsu ? lsu_prs2_re : alu_prs2_re;
   assign issue_prd     = pick_lsu ? lsu_prd     : alu_prd;
   assign issue_prd_we  = pick_lsu ? lsu_prd_we  : alu_prd_we;
   assign issue_rob_id  = pick_lsu ? lsu_rob_id  : alu_rob_id;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ptr_q <= UNIT_ALU;
      else if (issue_valid && issue_accept)
         ptr_q <= (issue_unit == UNIT_ALU) ? UNIT_LSU : UNIT_ALU;   // Hand over.
   end

endmodule

// File: design/issue_cluster.sv
`timescale 1ns/1ps

module issue_cluster import ooo_issue_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // Dispatch.
   input  logic    disp_push,
   input  unit_t   disp_unit,
   input  opcode_t disp_opc,
   input  imm_t    disp_imm,
   input  preg_t   disp_prs1,
   input  logic    disp_prs1_re,
   input  preg_t   disp_prs2,
   input  logic    disp_prs2_re,
   input  preg_t   disp_prd,
   input  logic    disp_prd_we,
   input  rob_id_t disp_rob_id,
   output logic    alu_rs_full,
   output logic    lsu_rs_full,
   // Writeback wakeup.
   input  logic    wb_valid,
   input  preg_t   wb_prd,
   // Issue port.
   output logic    issue_valid,
   output unit_t   issue_unit,
   output opcode_t issue_opc,
   output imm_t    issue_imm,
   output preg_t   issue_prs1,
   output logic    issue_prs1_re,
   output preg_t   issue_prs2,
   output logic    issue_prs2_re,
   output preg_t   issue_prd,
   output logic    issue_prd_we,
   output rob_id_t issue_rob_id,
   input  logic    issue_accept
);

   busy_vec_t busy;
   logic      alu_push;
   logic      lsu_push;

   logic      alu_valid, alu_pop, alu_prs1_re, alu_prs2_re, alu_prd_we;
   opcode_t   alu_opc;
   imm_t      alu_imm;
   preg_t     alu_prs1, alu_prs2, alu_prd;
   rob_id_t   alu_rob_id;

   logic      lsu_valid, lsu_pop, lsu_prs1_re, lsu_prs2_re, lsu_prd_we;
   opcode_t   lsu_opc;
   imm_t      lsu_imm;
   preg_t     lsu_prs1, lsu_prs2, lsu_prd;
   rob_id_t   lsu_rob_id;

   assign alu_push = disp_push & (disp_unit == UNIT_ALU);
   assign lsu_push = disp_push & (disp_unit == UNIT_LSU);

   busy_table u_busy (
      .clk(clk), .rst_n(rst_n),
      .set_en(disp_push & disp_prd_we), .set_prd(disp_prd),
      .clr_en(wb_valid), .clr_prd(wb_prd),
      .busy(busy)
   );

   rs_bank u_rs_alu (
      .clk(clk), .rst_n(rst_n), .push(alu_push),
      .opc(disp_opc), .imm(disp_imm),
      .prs1(disp_prs1), .prs1_re(disp_prs1_re), .prs2(disp_prs2), .prs2_re(disp_prs2_re),
      .prd(disp_prd), .prd_we(disp_prd_we), .rob_id(disp_rob_id),
      .busy(busy), .full(alu_rs_full), .sel_valid(alu_valid), .pop(alu_pop),
      .sel_opc(alu_opc), .sel_imm(alu_imm),
      .sel_prs1(alu_prs1), .sel_prs1_re(alu_prs1_re),
      .sel_prs2(alu_prs2), .sel_prs2_re(alu_prs2_re),
      .sel_prd(alu_prd), .sel_prd_we(alu_prd_we), .sel_rob_id(alu_rob_id)
   );

   rs_bank u_rs_lsu (
      .clk(clk), .rst_n(rst_n), .push(lsu_push),
      .opc(disp_opc), .imm(disp_imm),
      .prs1(disp_prs1), .prs1_re(disp_prs1_re), .prs2(disp_prs2), .prs2_re(disp_prs2_re),
      .prd(disp_prd), .prd_we(disp_prd_we), .rob_id(disp_rob_id),
      .busy(busy), .full(lsu_rs_full), .sel_valid(lsu_valid), .pop(lsu_pop),
      .sel_opc(lsu_opc), .sel_imm(lsu_imm),
      .sel_prs1(lsu_prs1), .sel_prs1_re(lsu_prs1_re),
      .sel_prs2(lsu_prs2), .sel_prs2_re(lsu_prs2_re),
      .sel_prd(lsu_prd), .sel_prd_we(lsu_prd_we), .sel_rob_id(lsu_rob_id)
   );

   issue_arbiter u_arb (
      .clk(clk), .rst_n(rst_n),
      .alu_valid(alu_valid), .alu_opc(alu_opc), .alu_imm(alu_imm),
      .alu_prs1(alu_prs1), .alu_prs1_re(alu_prs1_re),
      .alu_prs2(alu_prs2), .alu_prs2_re(alu_prs2_re),
      .alu_prd(alu_prd), .alu_prd_we(alu_prd_we), .alu_rob_id(alu_rob_id), .alu_pop(alu_pop),
      .lsu_valid(lsu_valid), .lsu_opc(lsu_opc), .lsu_imm(lsu_imm),
      .lsu_prs1(lsu_prs1), .lsu_prs1_re(lsu_prs1_re),
      .lsu_prs2(lsu_prs2), .lsu_prs2_re(lsu_prs2_re),
      .lsu_prd(lsu_prd), .lsu_prd_we(lsu_prd_we), .lsu_rob_id(lsu_rob_id), .lsu_pop(lsu_pop),
      .issue_accept(issue_accept), .issue_valid(issue_valid), .issue_unit(issue_unit),
      .issue_opc(issue_opc), .issue_imm(issue_imm),
      .issue_prs1(issue_prs1), .issue_prs1_re(issue_prs1_re),
      .issue_prs2(issue_prs2), .issue_prs2_re(issue_prs2_re),
      .issue_prd(issue_prd), .issue_prd_we(issue_prd_we), .issue_rob_id(issue_rob_id)
   );

endmodule

// File: design/ooo_issue_pkg.sv
package ooo_issue_pkg;

   // Physical register file.
   localparam int PREG_W   = 5;
   localparam int NUM_PREG = 1 << PREG_W;

   // Reorder buffer id.
   localparam int ROB_W = 4;

   // Operation payload.
   localparam int OPC_W = 8;
   localparam int IMM_W = 32;

   // Reservation station bank depth, as log2 of the entry count.
   localparam int RS_DEPTH_LOG2 = 3;

   typedef logic [PREG_W-1:0]        preg_t;
   typedef logic [NUM_PREG-1:0]      busy_vec_t;
   typedef logic [ROB_W-1:0]         rob_id_t;
   typedef logic [OPC_W-1:0]         opcode_t;
   typedef logic [IMM_W-1:0]         imm_t;
   typedef logic [RS_DEPTH_LOG2-1:0] rs_idx_t;

   // Target execution unit of an operation.
   typedef logic [0:0]               unit_t;

   localparam unit_t UNIT_ALU = 1'b0;
   localparam unit_t UNIT_LSU = 1'b1;

endpackage

// File: design/rs_bank.sv
`timescale 1ns/1ps

module rs_bank import ooo_issue_pkg::*;
#(
   parameter int DEPTH_LOG2 = RS_DEPTH_LOG2
)
(
   input  logic      clk,
   input  logic      rst_n,
   // Dispatch side.
   input  logic      push,
   input  opcode_t   opc,
   input  imm_t      imm,
   input  preg_t     prs1,
   input  logic      prs1_re,
   input  preg_t     prs2,
   input  logic      prs2_re,
   input  preg_t     prd,
   input  logic      prd_we,
   input  rob_id_t   rob_id,
   input  busy_vec_t busy,
   output logic      full,
   // Selected entry towards the arbiter.
   output logic      sel_valid,
   input  logic      pop,
   output opcode_t   sel_opc,
   output imm_t      sel_imm,
   output preg_t     sel_prs1,
   output logic      sel_prs1_re,
   output preg_t     sel_prs2,
   output logic      sel_prs2_re,
   output preg_t     sel_prd,
   output logic      sel_prd_we,
   output rob_id_t   sel_rob_id
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   // Payload memory.
   opcode_t              opc_mem    [DEPTH];
   imm_t                 imm_mem    [DEPTH];
   preg_t                prd_mem    [DEPTH];
   logic                 prd_we_mem [DEPTH];
   rob_id_t              rob_mem    [DEPTH];
   // Source tags, kept apart since every entry is checked each cycle.
   preg_t                prs1_mem   [DEPTH];
   preg_t                prs2_mem   [DEPTH];
   logic [DEPTH-1:0]     prs1_re_vec;
   logic [DEPTH-1:0]     prs2_re_vec;

   logic [DEPTH-1:0]     free_q;
   logic [DEPTH-1:0]     free_byp;
   logic [DEPTH-1:0]     free_nxt;
   logic [DEPTH-1:0]     rdy_vec;
   logic                 has_free;
   logic                 has_rdy;
   logic [DEPTH_LOG2-1:0] free_idx;
   logic [DEPTH_LOG2-1:0] rdy_idx;
   logic [DEPTH_LOG2-1:0] sel_idx_q;

   // Lowest set bit wins.
   function automatic logic [DEPTH_LOG2-1:0] pick_lowest(input logic [DEPTH-1:0] vec);
      logic [DEPTH_LOG2-1:0] idx;
      idx = '0;
      for (int i = DEPTH - 1; i >= 0; i--)
      begin
         if (vec[i])
            idx = DEPTH_LOG2'(i);
      end
      return idx;
   endfunction

   assign has_free = |free_q;
   assign free_idx = pick_lowest(free_q);   // No bypass, a popped slot refills next cycle.
   assign full     = ~has_free;

   always_comb
   begin
      free_byp = free_q;
      if (pop)
         free_byp[sel_idx_q] = 1'b1;         // Slot leaves this cycle.
      free_nxt = free_byp;
      if (push)
         free_nxt[free_idx] = 1'b0;
   end

   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         rdy_vec[i] = ~free_byp[i] &
                      (~prs1_re_vec[i] | ~busy[prs1_mem[i]]) &
                      (~prs2_re_vec[i] | ~busy[prs2_mem[i]]);
      end
   end

   assign has_rdy = |rdy_vec;
   assign rdy_idx = pick_lowest(rdy_vec);

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         opc_mem[free_idx]     <= opc;
         imm_mem[free_idx]     <= imm;
         prd_mem[free_idx]     <= prd;
         prd_we_mem[free_idx]  <= prd_we;
         rob_mem[free_idx]     <= rob_id;
         prs1_mem[free_idx]    <= prs1;
         prs2_mem[free_idx]    <= prs2;
         prs1_re_vec[free_idx] <= prs1_re;
         prs2_re_vec[free_idx] <= prs2_re;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         free_q    <= '1;                     // Every slot empty.
         sel_valid <= 1'b0;
         sel_idx_q <= '0;
      end
      else
      begin
         free_q    <= free_nxt;
         sel_valid <= has_rdy;                // Reloaded every cycle.
         if (has_rdy)
            sel_idx_q <= rdy_idx;
      end
   end

   always_ff @(posedge clk)
   begin
      if (has_rdy)
      begin
         sel_opc     <= opc_mem[rdy_idx];
         sel_imm     <= imm_mem[rdy_idx];
         sel_prs1    <= prs1_mem[rdy_idx];
         sel_prs1_re <= prs1_re_vec[rdy_idx];
         sel_prs2    <= prs2_mem[rdy_idx];
         sel_prs2_re <= prs2_re_vec[rdy_idx];
         sel_prd     <= prd_mem[rdy_idx];
         sel_prd_we  <= prd_we_mem[rdy_idx];
         sel_rob_id  <= rob_mem[rdy_idx];
      end
   end

endmodule

// File: filelist.f
design/ooo_issue_pkg.sv
design/busy_table.sv
design/rs_bank.sv
design/issue_arbiter.sv
design/issue_cluster.sv
testbench/tb_clk_gen.sv
testbench/tb_issue_cluster.sv

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;        // 8 ns period.
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;                // Release after 5 cycles.
   end

endmodule

// File: testbench/tb_issue_cluster.sv
`timescale 1ns/1ps

module tb_issue_cluster import ooo_issue_pkg::*;
();

   logic clk, rst_n;
   logic disp_push, disp_prs1_re, disp_prs2_re, disp_prd_we, wb_valid, issue_accept;
   unit_t disp_unit, issue_unit;
   opcode_t disp_opc, issue_opc;
   imm_t disp_imm, issue_imm;
   preg_t disp_prs1, disp_prs2, disp_prd, wb_prd, issue_prs1, issue_prs2, issue_prd;
   rob_id_t disp_rob_id, issue_rob_id;
   logic alu_rs_full, lsu_rs_full, issue_valid, issue_prs1_re, issue_prs2_re, issue_prd_we;

   // Model state indexed by ROB id.
   logic pend_valid [16];
   unit_t pend_unit [16];
   opcode_t pend_opc [16];
   imm_t pend_imm [16];
   preg_t pend_prs1 [16], pend_prs2 [16], pend_prd [16];
   logic pend_prs1_re [16], pend_prs2_re [16], pend_prd_we [16];
   busy_vec_t model_busy;
   unit_t last_unit;
   logic rr_check;
   logic [31:0] lcg_state;

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   issue_cluster DUT (.*);

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Ready when every enabled source is free in the model.
   function automatic logic op_ready(logic re1, preg_t s1, logic re2, preg_t s2, busy_vec_t b);
      return (!re1 || !b[s1]) && (!re2 || !b[s2]);
   endfunction

   function automatic unit_t expected_grant(logic alu_rdy, logic lsu_rdy, unit_t last);
      if (alu_rdy && lsu_rdy)
         return (last == UNIT_ALU) ? UNIT_LSU : UNIT_ALU;   // Alternate.
      return lsu_rdy ? UNIT_LSU : UNIT_ALU;
   endfunction

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_opc(string name, opcode_t got, opcode_t exp);
      if (got !== exp)
         report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_imm(string name, imm_t got, imm_t exp);
      if (got !== exp)
         report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_preg(string name, preg_t got, preg_t exp);
      if (got !== exp)
         report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_rob(string name, rob_id_t got, rob_id_t exp);
      if (got !== exp)
         report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp)
         report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_int(string name, int got, int exp);
      if (got != exp)
         report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   function automatic int pending_in(unit_t u);
      int n;
      n = 0;
      for (int i = 0; i < 16; i++)
         if (pend_valid[i] && pend_unit[i] == u)
            n++;
      return n;
   endfunction

   function automatic int free_rob();
      for (int i = 0; i < 16; i++)
         if (!pend_valid[i])
            return i;
      return -1;
   endfunction

   // Dest must be idle and read by no pending operation.
   function automatic logic dest_ok(preg_t r);
      if (model_busy[r])
         return 1'b0;
      for (int i = 0; i < 16; i++)
         if (pend_valid[i] && ((pend_prs1_re[i] && pend_prs1[i] == r) ||
                               (pend_prs2_re[i] && pend_prs2[i] == r)))
            return 1'b0;
      return 1'b1;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      disp_push <= 1'b0;
      wb_valid  <= 1'b0;
   endtask

   task automatic drive_push(unit_t u, opcode_t o, imm_t im, preg_t s1, logic re1,
                             preg_t s2, logic re2, preg_t d, logic we, output int rob);
      rob = free_rob();
      if (rob < 0)
         report_failure("No free ROB id for a push.");
      pend_valid[rob] = 1'b1;
      pend_unit[rob] = u;
      pend_opc[rob] = o;
      pend_imm[rob] = im;
      pend_prs1[rob] = s1;
      pend_prs1_re[rob] = re1;
      pend_prs2[rob] = s2;
      pend_prs2_re[rob] = re2;
      pend_prd[rob] = d;
      pend_prd_we[rob] = we;
      disp_push <= 1'b1;
      disp_unit <= u;
      disp_opc <= o;
      disp_imm <= im;
      disp_prs1 <= s1;
      disp_prs1_re <= re1;
      disp_prs2 <= s2;
      disp_prs2_re <= re2;
      disp_prd <= d;
      disp_prd_we <= we;
      disp_rob_id <= rob_id_t'(rob);
   endtask

   // Accept everything and wake all busy registers until the model is empty.
   task automatic drain(int limit);
      int cycles;
      cycles = 0;
      while (pending_in(UNIT_ALU) + pending_in(UNIT_LSU) != 0)
      begin
         next_cycle();
         issue_accept <= 1'b1;
         for (int r = 0; r < NUM_PREG; r++)
         begin
            if (model_busy[r] && !wb_valid)
            begin
               wb_valid <= 1'b1;
               wb_prd   <= preg_t'(r);
               break;
            end
         end
         cycles++;
         if (cycles > limit)
            report_failure("Timeout, pending operations were never issued.");
      end
      next_cycle();
   endtask

   // Compare process samples mid-cycle where every signal is stable.
   always @(negedge clk)
   begin
      int r;
      logic alu_rdy, lsu_rdy;
      if (rst_n)
      begin
         if (issue_valid && issue_accept)
         begin
            r = issue_rob_id;
            if (!pend_valid[r])
               report_failure("Issued operation matches no pending entry.");
            check_bit("issue_unit", issue_unit, pend_unit[r]);
            check_opc("issue_opc", issue_opc, pend_opc[r]);
            check_imm("issue_imm", issue_imm, pend_imm[r]);
            check_preg("issue_prs1", issue_prs1, pend_prs1[r]);
            check_bit("issue_prs1_re", issue_prs1_re, pend_prs1_re[r]);
            check_preg("issue_prs2", issue_prs2, pend_prs2[r]);
            check_bit("issue_prs2_re", issue_prs2_re, pend_prs2_re[r]);
            check_preg("issue_prd", issue_prd, pend_prd[r]);
            check_bit("issue_prd_we", issue_prd_we, pend_prd_we[r]);
            check_rob("issue_rob_id", issue_rob_id, rob_id_t'(r));
            if (!op_ready(pend_prs1_re[r], pend_prs1[r], pend_prs2_re[r], pend_prs2[r],
                          model_busy))
               report_failure("Operation issued while a source was still busy.");
            if (rr_check)
            begin
               alu_rdy = 1'b0;
               lsu_rdy = 1'b0;
               for (int i = 0; i < 16; i++)
               begin
                  if (pend_valid[i] && op_ready(pend_prs1_re[i], pend_prs1[i],
                                                pend_prs2_re[i], pend_prs2[i], model_busy))
                  begin
                     if (pend_unit[i] == UNIT_ALU)
                        alu_rdy = 1'b1;
                     else
                        lsu_rdy = 1'b1;
                  end
               end
               check_bit("issue_unit", issue_unit, expected_grant(alu_rdy, lsu_rdy, last_unit));
            end
            last_unit = issue_unit;
            pend_valid[r] = 1'b0;
         end
         if (disp_push && ((disp_unit == UNIT_ALU) ? alu_rs_full : lsu_rs_full))
            report_failure("Push into a bank whose full flag is high.");
         if (wb_valid)
            model_busy[wb_prd] = 1'b0;
         if (disp_push && disp_prd_we)
            model_busy[disp_prd] = 1'b1;      // Set wins over clear.
      end
   end

   initial
   begin
      int rob, rob_b, cnt, u, dst, st;
      logic [31:0] rnd;
      preg_t s1, s2;
      logic re1, re2, we;
      disp_push = 0;
      disp_unit = UNIT_ALU;
      disp_opc = '0;
      disp_imm = '0;
      disp_prs1 = '0;
      disp_prs1_re = 0;
      disp_prs2 = '0;
      disp_prs2_re = 0;
      disp_prd = '0;
      disp_prd_we = 0;
      disp_rob_id = '0;
      wb_valid = 0;
      wb_prd = '0;
      issue_accept = 0;
      for (int i = 0; i < 16; i++)
         pend_valid[i] = 1'b0;
      model_busy = '0;
      last_unit = UNIT_LSU;                   // Pointer prefers the ALU bank.
      rr_check = 0;
      lcg_state = 32'h9a0e;

      cnt = 0;
      while (!rst_n)
      begin
         @(posedge clk);
         cnt++;
         if (cnt > 20)
            report_failure("Timeout, reset was never released.");
      end
      next_cycle();
      #1;
      check_bit("issue_valid", issue_valid, 1'b0);
      check_bit("alu_rs_full", alu_rs_full, 1'b0);
      check_bit("lsu_rs_full", lsu_rs_full, 1'b0);

      // 1. Latency of one independent ALU operation.
      next_cycle();
      issue_accept <= 1'b1;
      drive_push(UNIT_ALU, 8'h3c, 32'hdead_beef, 5'd1, 0, 5'd2, 0, 5'd3, 0, rob);
      cnt = 0;
      do
      begin
         next_cycle();
         cnt++;
         #1;
         if (cnt > 20)
            report_failure("Timeout, first operation never reached the issue port.");
      end
      while (!issue_valid);
      check_int("issue latency", cnt, 2);
      check_bit("issue_unit", issue_unit, UNIT_ALU);
      drain(50);

      // 2. Wakeup of a dependent operation.
      next_cycle();
      drive_push(UNIT_ALU, 8'h11, 32'h1, 5'd0, 0, 5'd0, 0, 5'd5, 1, rob);
      next_cycle();
      drive_push(UNIT_ALU, 8'h12, 32'h2, 5'd5, 1, 5'd0, 0, 5'd6, 0, rob_b);
      repeat (6) next_cycle();
      #1;
      check_bit("dependent pending", pend_valid[rob_b], 1'b1);
      check_bit("issue_valid", issue_valid, 1'b0);
      next_cycle();
      wb_valid <= 1'b1;
      wb_prd   <= 5'd5;
      cnt = 0;
      do
      begin
         next_cycle();
         cnt++;
         #1;
         if (cnt > 20)
            report_failure("Timeout, woken operation was never issued.");
      end
      while (pend_valid[rob_b]);
      drain(50);

      // 3. Back-pressure fills the ALU bank only.
      next_cycle();
      issue_accept <= 1'b0;
      for (int i = 0; i < 8; i++)
      begin
         if (i > 0)
            next_cycle();
         drive_push(UNIT_ALU, 8'(8'h40 + i), 32'(i * 3), 5'd0, 0, 5'd0, 0, 5'd0, 0, rob);
      end
      next_cycle();
      #1;
      check_bit("alu_rs_full", alu_rs_full, 1'b1);
      check_bit("lsu_rs_full", lsu_rs_full, 1'b0);
      next_cycle();
      drive_push(UNIT_LSU, 8'h80, 32'h100, 5'd0, 0, 5'd0, 0, 5'd0, 0, rob);
      next_cycle();
      drive_push(UNIT_LSU, 8'h81, 32'h104, 5'd0, 0, 5'd0, 0, 5'd0, 0, rob);
      repeat (3) next_cycle();
      #1;
      check_bit("alu_rs_full", alu_rs_full, 1'b1);
      check_bit("issue_valid", issue_valid, 1'b1);
      drain(100);

      // 4. Round-robin between two loaded banks.
      issue_accept <= 1'b0;
      for (int i = 0; i < 8; i++)
      begin
         next_cycle();
         drive_push(unit_t'(i[0]), 8'(8'h90 + i), 32'(i), 5'd0, 0, 5'd0, 0, 5'd0, 0, rob);
      end
      repeat (3) next_cycle();
      rr_check = 1'b1;
      drain(100);
      rr_check = 1'b0;

      // 5. Random mix of pushes, wakeups and accept patterns.
      for (int n = 0; n < 400; n++)
      begin
         next_cycle();
         rnd = lcg_next();
         issue_accept <= (rnd[3:2] != 2'b00);
         u = rnd[4];
         if (rnd[7:6] != 2'b00 && free_rob() >= 0 && pending_in(unit_t'(u)) < 8)
         begin
            rnd = lcg_next();
            s1 = rnd[4:0];
            s2 = rnd[9:5];
            re1 = rnd[10];
            re2 = rnd[11];
            we = rnd[12];
            dst = -1;
            st = rnd[17:13];
            for (int k = 0; k < NUM_PREG; k++)
            begin
               if (dst < 0 && dest_ok(preg_t'(st + k)) &&
                   preg_t'(st + k) != s1 && preg_t'(st + k) != s2)
                  dst = (st + k) % NUM_PREG;
            end
            if (dst < 0)
               we = 1'b0;
            drive_push(unit_t'(u), opcode_t'(lcg_next()), lcg_next(), s1, re1, s2, re2,
                       preg_t'(dst < 0 ? 0 : dst), we, rob);
         end
         rnd = lcg_next();
         if (rnd[1:0] == 2'b00 && model_busy != '0)
         begin
            st = rnd[8:4];
            for (int k = 0; k < NUM_PREG; k++)
            begin
               if (!wb_valid && model_busy[preg_t'(st + k)])
               begin
                  wb_valid <= 1'b1;
                  wb_prd   <= preg_t'(st + k);
                  break;
               end
            end
         end
      end
      drain(400);

      $display("Result: PASSED");
      $finish;
   end

endmodule
